// ==== rtl/memPipePkg.sv ====
// Memory pipeline package
// Widths, op and stage structs, operand-type codes and the
// selective-flush check shared by the load/store back-end slice

package memPipePkg;

    localparam int DATA_WIDTH   = 32;
    localparam int PREG_NUM     = 32;
    localparam int AL_PTR_WIDTH = 5;
    localparam int OFFSET_WIDTH = 12;

    typedef logic [$clog2(PREG_NUM)-1:0] PRegNum;
    typedef logic [AL_PTR_WIDTH-1:0] ActiveListPtr;

    typedef enum logic [1:0] {
        operandReg = 2'd0,
        operandImm = 2'd1,
        operandPc  = 2'd2
    } OperandType;

    typedef enum logic {
        memLoad  = 1'b0,
        memStore = 1'b1
    } MemOpType;

    // Op as it leaves the scheduler
    typedef struct packed {
        MemOpType               opType;
        OperandType             operandTypeA;
        OperandType             operandTypeB;
        PRegNum                 srcRegA;
        PRegNum                 srcRegB;
        PRegNum                 dstReg;
        logic                   writeReg;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [DATA_WIDTH-1:0]  pc;
        ActiveListPtr           activeListPtr;
    } MemOp;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } RegOperand;

    typedef struct packed {
        logic valid;
        MemOp op;
    } IssueStageReg;

    typedef struct packed {
        logic      valid;
        MemOp      op;
        RegOperand operandA;
        RegOperand operandB;
    } RegReadStageReg;

    typedef struct packed {
        logic                  valid;
        logic                  replay;
        logic                  isStore;
        logic [DATA_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] storeData;
        PRegNum                dstReg;
        logic                  writeReg;
        ActiveListPtr          activeListPtr;
    } MemRequest;

    typedef struct packed {
        logic         flush;
        logic         flushAll;
        ActiveListPtr headPtr;
        ActiveListPtr tailPtr;
    } RecoveryCtrl;

    typedef struct packed {
        logic                  valid;
        PRegNum                regNum;
        logic [DATA_WIDTH-1:0] data;
    } WriteBack;

    // Range is [head, tail) and wraps around the active list
    function automatic logic isFlushed(RecoveryCtrl rec, ActiveListPtr ptr);
        logic inRange;
        if (rec.headPtr < rec.tailPtr) begin
            inRange = (ptr >= rec.headPtr) && (ptr < rec.tailPtr);
        end else if (rec.headPtr > rec.tailPtr) begin
            inRange = (ptr >= rec.headPtr) || (ptr < rec.tailPtr);
        end else begin
            inRange = 1'b0;
        end
        return rec.flush && (rec.flushAll || inRange);
    endfunction

endpackage

// ==== rtl/physRegFile.sv ====
// Physical register file with a ready bit per entry
// Two combinational read ports with write-through, one writeback
// port and one allocate port that clears ready

`timescale 1ns/1ps

module physRegFile (
    input  logic                  clk,
    input  logic                  reset,
    input  memPipePkg::PRegNum    readRegA,
    input  memPipePkg::PRegNum    readRegB,
    output memPipePkg::RegOperand readDataA,
    output memPipePkg::RegOperand readDataB,
    input  memPipePkg::WriteBack  wb,
    input  logic                  allocValid,
    input  memPipePkg::PRegNum    allocReg
);

    logic [memPipePkg::DATA_WIDTH-1:0] regData [memPipePkg::PREG_NUM];
    logic [memPipePkg::PREG_NUM-1:0]   regReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            regReady <= '1;
            for (int i = 0; i < memPipePkg::PREG_NUM; i++) begin
                regData[i] <= '0;
            end
        end else begin
            // Writeback after allocate so it wins on the same entry
            if (allocValid) begin
                regReady[allocReg] <= 1'b0;
            end
            if (wb.valid) begin
                regData[wb.regNum]  <= wb.data;
                regReady[wb.regNum] <= 1'b1;
            end
        end
    end

    // Write-through of a writeback in flight
    always_comb begin
        if (wb.valid && (wb.regNum == readRegA)) begin
            readDataA.valid = 1'b1;
            readDataA.data  = wb.data;
        end else begin
            readDataA.valid = regReady[readRegA];
            readDataA.data  = regData[readRegA];
        end

        if (wb.valid && (wb.regNum == readRegB)) begin
            readDataB.valid = 1'b1;
            readDataB.data  = wb.data;
        end else begin
            readDataB.valid = regReady[readRegB];
            readDataB.data  = regData[readRegB];
        end
    end

endmodule

// ==== rtl/memIssueStage.sv ====
// Issue latch of the memory pipeline
// Captures scheduled ops and holds them while the back end stalls

`timescale 1ns/1ps

module memIssueStage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     inValid,
    input  memPipePkg::MemOp         inOp,
    output memPipePkg::IssueStageReg nextStage
);

    memPipePkg::IssueStageReg pipeReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg.valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeReg.op <= inOp;
        end
    end

    assign nextStage = pipeReg;

endmodule

// ==== rtl/memRegReadStage.sv ====
// Register read stage of the memory pipeline
// Reads both sources, picks register, PC or zero per operand type,
// and drops ops on stall, clear or a matching recovery flush

`timescale 1ns/1ps

module memRegReadStage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       clear,
    input  memPipePkg::RecoveryCtrl    recovery,
    input  memPipePkg::IssueStageReg   prev,
    output memPipePkg::PRegNum         readRegA,
    output memPipePkg::PRegNum         readRegB,
    input  memPipePkg::RegOperand      readDataA,
    input  memPipePkg::RegOperand      readDataB,
    output memPipePkg::RegReadStageReg nextStage
);

    memPipePkg::IssueStageReg pipeReg;
    memPipePkg::RegOperand    operandA;
    memPipePkg::RegOperand    operandB;
    logic                     flushed;

    // Non-register operands are always ready
    function automatic memPipePkg::RegOperand selectOperand(
        memPipePkg::OperandType       opType,
        memPipePkg::RegOperand        regValue,
        logic [memPipePkg::DATA_WIDTH-1:0] pcValue
    );
        memPipePkg::RegOperand result;
        case (opType)
            memPipePkg::operandImm: begin
                result.valid = 1'b1;
                result.data  = '0;
            end
            memPipePkg::operandPc: begin
                result.valid = 1'b1;
                result.data  = pcValue;
            end
            default: begin
                result = regValue;
            end
        endcase
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg.valid <= prev.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeReg.op <= prev.op;
        end
    end

    assign readRegA = pipeReg.op.srcRegA;
    assign readRegB = pipeReg.op.srcRegB;

    always_comb begin
        operandA = selectOperand(pipeReg.op.operandTypeA, readDataA, pipeReg.op.pc);
        operandB = selectOperand(pipeReg.op.operandTypeB, readDataB, pipeReg.op.pc);
        flushed  = memPipePkg::isFlushed(recovery, pipeReg.op.activeListPtr);

        // Bubble out on stall, clear, reset or a flush hit
        nextStage.valid    = (stall || clear || reset || flushed) ? 1'b0 : pipeReg.valid;
        nextStage.op       = pipeReg.op;
        nextStage.operandA = operandA;
        nextStage.operandB = operandB;
    end

endmodule

// ==== rtl/memExecStage.sv ====
// Address execute stage of the memory pipeline
// Adds the sign-extended offset to operand A, passes operand B as
// store data and flags a replay when a source was not ready

`timescale 1ns/1ps

module memExecStage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  memPipePkg::RegReadStageReg prev,
    output memPipePkg::MemRequest      out
);

    localparam int ExtWidth = memPipePkg::DATA_WIDTH - memPipePkg::OFFSET_WIDTH;

    memPipePkg::RegReadStageReg        pipeReg;
    logic [memPipePkg::DATA_WIDTH-1:0] offsetExt;
    logic                              isStore;

    always_ff @(posedge clk) begin
        if (reset) begin
            pipeReg.valid <= 1'b0;
        end else if (!stall) begin
            pipeReg.valid <= prev.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipeReg.op       <= prev.op;
            pipeReg.operandA <= prev.operandA;
            pipeReg.operandB <= prev.operandB;
        end
    end

    assign offsetExt = {{ExtWidth{pipeReg.op.offset[memPipePkg::OFFSET_WIDTH-1]}},
                        pipeReg.op.offset};
    assign isStore   = (pipeReg.op.opType == memPipePkg::memStore);

    always_comb begin
        // Held op is hidden until the stall lifts
        out.valid  = pipeReg.valid && !stall;
        out.replay = pipeReg.valid && !(pipeReg.operandA.valid && pipeReg.operandB.valid);
        out.isStore   = isStore;
        out.address   = pipeReg.operandA.data + offsetExt;
        out.storeData = isStore ? pipeReg.operandB.data : '0;
        out.dstReg        = pipeReg.op.dstReg;
        out.writeReg      = pipeReg.op.writeReg;
        out.activeListPtr = pipeReg.op.activeListPtr;
    end

endmodule

// ==== rtl/memPipeTop.sv ====
// Load/store back-end slice
// Issue latch, register read and address execute around a
// physical register file

`timescale 1ns/1ps

module memPipeTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    clear,
    input  logic                    inValid,
    input  memPipePkg::MemOp        inOp,
    input  memPipePkg::RecoveryCtrl recovery,
    input  memPipePkg::WriteBack    wb,
    input  logic                    allocValid,
    input  memPipePkg::PRegNum      allocReg,
    output memPipePkg::MemRequest   out
);

    memPipePkg::IssueStageReg   issueToRegRead;
    memPipePkg::RegReadStageReg regReadToExec;
    memPipePkg::PRegNum         readRegA;
    memPipePkg::PRegNum         readRegB;
    memPipePkg::RegOperand      readDataA;
    memPipePkg::RegOperand      readDataB;

    physRegFile i_regFile (
        .clk       (clk),
        .reset     (reset),
        .readRegA  (readRegA),
        .readRegB  (readRegB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .wb        (wb),
        .allocValid(allocValid),
        .allocReg  (allocReg)
    );

    memIssueStage i_issue (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .inValid  (inValid),
        .inOp     (inOp),
        .nextStage(issueToRegRead)
    );

    memRegReadStage i_regRead (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .clear    (clear),
        .recovery (recovery),
        .prev     (issueToRegRead),
        .readRegA (readRegA),
        .readRegB (readRegB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .nextStage(regReadToExec)
    );

    memExecStage i_exec (
        .clk  (clk),
        .reset(reset),
        .stall(stall),
        .prev (regReadToExec),
        .out  (out)
    );

endmodule

// ==== dv/memPipeTb.sv ====
// Testbench for the load/store back-end slice
// Runs a table of ops through the pipeline with stall, clear, flush
// and register file events and checks each request against a model

`timescale 1ns/1ps

module memPipeTb;

    typedef logic [memPipePkg::DATA_WIDTH-1:0] DataWord;

    // wbMode 0 is none, 1 writes srcA before the op, 2 during register read
    // A zero offset in the table draws a random one
    typedef struct packed {
        memPipePkg::MemOpType                opType;
        memPipePkg::OperandType              typeA;
        memPipePkg::OperandType              typeB;
        memPipePkg::PRegNum                  srcA;
        memPipePkg::PRegNum                  srcB;
        logic [memPipePkg::OFFSET_WIDTH-1:0] offset;
        memPipePkg::ActiveListPtr            alPtr;
        logic [3:0]                          stallCycles;
        logic                                clear;
        memPipePkg::RecoveryCtrl             rec;
        logic                                allocA;
        logic [1:0]                          wbMode;
        logic                                expectDrop;
    } TestEntry;

    localparam int numTests = 12;
    localparam memPipePkg::MemOpType    load       = memPipePkg::memLoad;
    localparam memPipePkg::MemOpType    store      = memPipePkg::memStore;
    localparam memPipePkg::OperandType  opReg      = memPipePkg::operandReg;
    localparam memPipePkg::OperandType  opImm      = memPipePkg::operandImm;
    localparam memPipePkg::OperandType  opPc       = memPipePkg::operandPc;
    localparam memPipePkg::RecoveryCtrl noFlush    = '0;
    localparam memPipePkg::RecoveryCtrl flushEvery = '{1'b1, 1'b1, 5'd0, 5'd0};
    localparam memPipePkg::RecoveryCtrl wrapRange  = '{1'b1, 1'b0, 5'd28, 5'd3};

    string names [numTests] = '{"loadRegPos", "loadRegNeg", "storePcReg", "storeRegImm",
        "replayAlloc", "replayWbBefore", "replayWriteThrough", "flushAll", "flushWrapIn",
        "flushWrapOut", "clearDrop", "stallThree"};

    TestEntry tests [numTests] = '{
        '{load, opReg, opImm, 5'd3, 5'd0, 12'h024, 5'd1, 4'd0, 1'b0, noFlush, 1'b0, 2'd0, 1'b0},
        '{load, opReg, opImm, 5'd5, 5'd0, 12'hff0, 5'd2, 4'd0, 1'b0, noFlush, 1'b0, 2'd0, 1'b0},
        '{store, opPc, opReg, 5'd0, 5'd12, 12'h000, 5'd4, 4'd0, 1'b0, noFlush, 1'b0, 2'd0, 1'b0},
        '{store, opReg, opImm, 5'd14, 5'd0, 12'h000, 5'd5, 4'd0, 1'b0, noFlush, 1'b0, 2'd0, 1'b0},
        // Allocated source, then written back before and during register read
        // The second entry allocates and writes back in the same cycle
        '{load, opReg, opImm, 5'd20, 5'd0, 12'h000, 5'd6, 4'd0, 1'b0, noFlush, 1'b1, 2'd0, 1'b0},
        '{load, opReg, opImm, 5'd20, 5'd0, 12'h000, 5'd6, 4'd0, 1'b0, noFlush, 1'b1, 2'd1, 1'b0},
        '{load, opReg, opImm, 5'd20, 5'd0, 12'h000, 5'd6, 4'd0, 1'b0, noFlush, 1'b1, 2'd2, 1'b0},
        // Flush range is [28, 3) so pointer 1 is inside and 10 is not
        '{load, opReg, opImm, 5'd7, 5'd0, 12'h000, 5'd7, 4'd0, 1'b0, flushEvery, 1'b0, 2'd0, 1'b1},
        '{load, opReg, opImm, 5'd8, 5'd0, 12'h000, 5'd1, 4'd0, 1'b0, wrapRange, 1'b0, 2'd0, 1'b1},
        '{load, opReg, opImm, 5'd8, 5'd0, 12'h000, 5'd10, 4'd0, 1'b0, wrapRange, 1'b0, 2'd0, 1'b0},
        '{load, opReg, opImm, 5'd9, 5'd0, 12'h000, 5'd11, 4'd0, 1'b1, noFlush, 1'b0, 2'd0, 1'b1},
        '{store, opReg, opReg, 5'd10, 5'd11, 12'h000, 5'd12, 4'd3, 1'b0, noFlush, 1'b0, 2'd0, 1'b0}
    };

    logic                            clk;
    logic                            reset;
    logic                            stall;
    logic                            clear;
    logic                            inValid;
    logic                            allocValid;
    memPipePkg::PRegNum              allocReg;
    memPipePkg::MemOp                inOp;
    memPipePkg::RecoveryCtrl         recovery;
    memPipePkg::WriteBack            wb;
    memPipePkg::MemRequest           out;

    DataWord                         regModel [memPipePkg::PREG_NUM];
    logic [memPipePkg::PREG_NUM-1:0] readyModel;
    logic [31:0]                     lfsrState;
    int                              checkCount;
    int                              valueErrors;
    int                              otherErrors;

    memPipeTop i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR over taps 32, 22, 2 and 1 stepped once per bit
    function automatic DataWord randomBits(int width);
        DataWord value;
        logic    feedback;
        value = '0;
        for (int i = 0; i < width; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            value     = {value[30:0], lfsrState[31]};
            lfsrState = {lfsrState[30:0], feedback};
        end
        return value;
    endfunction

    function automatic memPipePkg::RegOperand modelOperand(memPipePkg::OperandType kind,
                                                           memPipePkg::PRegNum regNum,
                                                           DataWord pc);
        memPipePkg::RegOperand value;
        value.valid = 1'b1;
        value.data  = '0;
        if (kind == memPipePkg::operandReg) begin
            value.valid = readyModel[regNum];
            value.data  = regModel[regNum];
        end else if (kind == memPipePkg::operandPc) begin
            value.data = pc;
        end
        return value;
    endfunction

    function automatic memPipePkg::MemRequest expectRequest(memPipePkg::MemOp op);
        memPipePkg::RegOperand a;
        memPipePkg::RegOperand b;
        memPipePkg::MemRequest req;
        a = modelOperand(op.operandTypeA, op.srcRegA, op.pc);
        b = modelOperand(op.operandTypeB, op.srcRegB, op.pc);
        req.valid         = 1'b1;
        req.replay        = !(a.valid && b.valid);
        req.isStore       = (op.opType == memPipePkg::memStore);
        req.address       = a.data + DataWord'($signed(op.offset));
        req.storeData     = req.isStore ? b.data : '0;
        req.dstReg        = op.dstReg;
        req.writeReg      = op.writeReg;
        req.activeListPtr = op.activeListPtr;
        return req;
    endfunction

    task automatic checkMemRequest(string name, memPipePkg::MemRequest expected,
                                   memPipePkg::MemRequest actual);
        checkCount++;
        if (actual !== expected) begin
            valueErrors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkLatency(string name, int expected, int actual);
        checkCount++;
        if (actual != expected) begin
            valueErrors++;
            $display("Fail %s latency: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkDropped(string name, logic seen);
        checkCount++;
        if (seen) begin
            otherErrors++;
            $display("Error in %s: an op that should be dropped reached the output", name);
        end
    endtask

    task automatic preloadRegs();
        DataWord value;
        for (int i = 0; i < memPipePkg::PREG_NUM; i++) begin
            value       = randomBits(32);
            regModel[i] = value;
            @(posedge clk);
            wb <= '{valid: 1'b1, regNum: memPipePkg::PRegNum'(i), data: value};
        end
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic runTest(int idx);
        TestEntry              e;
        memPipePkg::MemOp      op;
        memPipePkg::MemRequest expected;
        memPipePkg::MemRequest actual;
        DataWord               newData;
        logic                  seen;
        int                    cycles;
        e       = tests[idx];
        newData = randomBits(32);
        op.opType        = e.opType;
        op.operandTypeA  = e.typeA;
        op.operandTypeB  = e.typeB;
        op.srcRegA       = e.srcA;
        op.srcRegB       = e.srcB;
        op.dstReg        = memPipePkg::PRegNum'(randomBits(5));
        op.writeReg      = (e.opType == memPipePkg::memLoad);
        op.offset        = (e.offset == '0) ? 12'(randomBits(12)) : e.offset;
        op.pc            = randomBits(32);
        op.activeListPtr = e.alPtr;

        // Writeback wins over allocate on the same register
        if (e.allocA) begin
            readyModel[e.srcA] = 1'b0;
        end
        if (e.wbMode != 2'd0) begin
            regModel[e.srcA]   = newData;
            readyModel[e.srcA] = 1'b1;
        end
        expected = expectRequest(op);
        actual   = '0;
        seen     = 1'b0;

        @(posedge clk);
        inValid    <= 1'b1;
        inOp       <= op;
        allocValid <= e.allocA;
        allocReg   <= e.srcA;
        if (e.wbMode == 2'd1) begin
            wb <= '{valid: 1'b1, regNum: e.srcA, data: newData};
        end
        @(posedge clk);
        inValid    <= 1'b0;
        allocValid <= 1'b0;
        wb         <= '0;
        @(posedge clk);
        // Op sits in register read for this cycle
        recovery <= e.rec;
        clear    <= e.clear;
        if (e.wbMode == 2'd2) begin
            wb <= '{valid: 1'b1, regNum: e.srcA, data: newData};
        end
        @(posedge clk);
        recovery <= '0;
        clear    <= 1'b0;
        wb       <= '0;
        stall    <= (e.stallCycles != 4'd0);
        cycles = 2;
        while (!seen && cycles < 20) begin
            @(negedge clk);
            if (out.valid) begin
                seen   = 1'b1;
                actual = out;
            end else begin
                @(posedge clk);
                cycles++;
                if (cycles == 2 + int'(e.stallCycles)) begin
                    stall <= 1'b0;
                end
            end
        end

        if (e.expectDrop) begin
            checkDropped(names[idx], seen);
        end else if (!seen) begin
            otherErrors++;
            $display("Error in %s: timed out waiting for out.valid", names[idx]);
        end else begin
            checkMemRequest(names[idx], expected, actual);
            checkLatency(names[idx], 3 + int'(e.stallCycles), cycles + 1);
        end
    endtask

    initial begin
        reset       = 1'b1;
        stall       = 1'b0;
        clear       = 1'b0;
        inValid     = 1'b0;
        inOp        = '0;
        recovery    = '0;
        wb          = '0;
        allocValid  = 1'b0;
        allocReg    = '0;
        lfsrState   = 32'h8f58_b6bf;
        readyModel  = '1;
        checkCount  = 0;
        valueErrors = 0;
        otherErrors = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        preloadRegs();
        for (int i = 0; i < numTests; i++) begin
            runTest(i);
        end
        $display("Summary: %0d checks, %0d wrong values, %0d other errors",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== memPipe.f ====
rtl/memPipePkg.sv
rtl/physRegFile.sv
rtl/memIssueStage.sv
rtl/memRegReadStage.sv
rtl/memExecStage.sv
rtl/memPipeTop.sv
dv/memPipeTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = memPipeTb
FILELIST = memPipe.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
